// File: include/corHX_macros.svh
`ifndef CORHX_MACROS_SVH
`define CORHX_MACROS_SVH

////////////////////////////////////////
// Scratch memory geometry
////////////////////////////////////////

// Word address into the scratch RAM
`define CORHX_ADDR_W 12

// One RAM word holds a G.729 accumulator
`define CORHX_DATA_W 32

////////////////////////////////////////
// Algorithm sizes
////////////////////////////////////////

// Samples per subframe
`define CORHX_L_SUBFR 40

// One memory region per vector
`define CORHX_X_BASE 12'd0
`define CORHX_H_BASE 12'd64
// Unscaled correlation words
`define CORHX_Y32_BASE 12'd128
`define CORHX_DN_BASE 12'd192

`endif

// File: design/g729TypesPkg.sv
package g729TypesPkg;

	////////////////////////////////////////
	// Fixed-point word types
	////////////////////////////////////////

	// Q15 sample
	typedef logic signed [15:0] word16;

	// Q31 accumulator
	typedef logic signed [31:0] word32;

	////////////////////////////////////////
	// Saturation limits
	////////////////////////////////////////

	localparam word16 maxWord16 = 16'sh7FFF;
	localparam word16 minWord16 = 16'sh8000;

	localparam word32 maxWord32 = 32'sh7FFF_FFFF;
	localparam word32 minWord32 = 32'sh8000_0000;

endpackage

// File: design/corHXPkg.sv
package corHXPkg;

	// Cor_h_X controller states
	typedef enum logic [3:0]
	{
		IDLE,
		// Correlation loop over i and j
		CLEAR_ACC,
		READ_X,
		READ_H,
		MAC,
		STORE_Y,
		FIND_MAX,
		// Block normalization
		START_NORM,
		WAIT_NORM,
		CALC_SHIFT,
		// Scaling pass into dn
		READ_Y,
		WRITE_DN,
		FINISH
	} corHXState;

endpackage

// File: design/basicOps.sv
`timescale 1ns/100ps

module basicOps
(
	input  g729TypesPkg::word16 macA,
	input  g729TypesPkg::word16 macB,
	input  g729TypesPkg::word32 macC,
	output g729TypesPkg::word32 macOut,
	input  g729TypesPkg::word32 absIn,
	output g729TypesPkg::word32 absOut,
	input  g729TypesPkg::word32 subLA,
	input  g729TypesPkg::word32 subLB,
	output g729TypesPkg::word32 subLOut,
	input  g729TypesPkg::word16 addA,
	input  g729TypesPkg::word16 addB,
	output g729TypesPkg::word16 addOut,
	input  g729TypesPkg::word16 subA,
	input  g729TypesPkg::word16 subB,
	output g729TypesPkg::word16 subOut,
	input  g729TypesPkg::word32 shrVar,
	input  g729TypesPkg::word16 shrCount,
	output g729TypesPkg::word32 shrOut
);

	g729TypesPkg::word32 macProd;
	g729TypesPkg::word32 macMult;
	logic [32:0] macSum;
	logic [32:0] subLDiff;
	logic [16:0] addSum;
	logic [16:0] subDiff;
	logic [5:0] shlAmt;
	g729TypesPkg::word32 shlVal;

	////////////////////////////////////////
	// L_mac
	////////////////////////////////////////

	assign macProd = macA * macB;
	// -1 * -1 in Q15 is the one product that overflows L_mult
	assign macMult = (macProd == 32'sh4000_0000) ? g729TypesPkg::maxWord32 : macProd <<< 1;
	assign macSum = {macC[31], macC} + {macMult[31], macMult};
	assign macOut = (macSum[32] != macSum[31]) ?
		(macSum[32] ? g729TypesPkg::minWord32 : g729TypesPkg::maxWord32) : macSum[31:0];

	// L_abs
	assign absOut = (absIn == g729TypesPkg::minWord32) ? g729TypesPkg::maxWord32 :
		(absIn[31] ? -absIn : absIn);

	// L_sub
	assign subLDiff = {subLA[31], subLA} - {subLB[31], subLB};
	assign subLOut = (subLDiff[32] != subLDiff[31]) ?
		(subLDiff[32] ? g729TypesPkg::minWord32 : g729TypesPkg::maxWord32) : subLDiff[31:0];

	////////////////////////////////////////
	// 16-bit add and sub
	////////////////////////////////////////

	assign addSum = {addA[15], addA} + {addB[15], addB};
	assign addOut = (addSum[16] != addSum[15]) ?
		(addSum[16] ? g729TypesPkg::minWord16 : g729TypesPkg::maxWord16) : addSum[15:0];

	assign subDiff = {subA[15], subA} - {subB[15], subB};
	assign subOut = (subDiff[16] != subDiff[15]) ?
		(subDiff[16] ? g729TypesPkg::minWord16 : g729TypesPkg::maxWord16) : subDiff[15:0];

	// L_shr with a negative count acts as a saturating L_shl
	always_comb
	begin
		shlAmt = 6'd0;
		shlVal = shrVar;
		if (shrCount < 0)
		begin
			shlAmt = (shrCount < -16'sd32) ? 6'd32 : 6'(-shrCount);
			shlVal = shrVar <<< shlAmt;
			// Bits lost off the top mean saturation
			if ((shlVal >>> shlAmt) == shrVar)
				shrOut = shlVal;
			else
				shrOut = shrVar[31] ? g729TypesPkg::minWord32 : g729TypesPkg::maxWord32;
		end
		else if (shrCount >= 31)
			shrOut = shrVar[31] ? -32'sd1 : 32'sd0;
		else
			shrOut = shrVar >>> shrCount[4:0];
	end

endmodule

// File: design/normL.sv
`timescale 1ns/100ps

module normL
(
	input  logic clk,
	input  logic rst,
	input  g729TypesPkg::word32 normVar1,
	input  logic normReady,
	output g729TypesPkg::word16 normValue,
	output logic normDone
);

	logic busy;
	logic [4:0] shiftCount;
	g729TypesPkg::word32 shiftReg;

	// One shift per cycle while busy
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			normDone <= 1'b0;
		end
		else
		begin
			normDone <= 1'b0;
			if (normReady)
			begin
				// Zero and all-ones are answered without shifting
				if ((normVar1 == 32'sd0) || (normVar1 == -32'sd1))
					normDone <= 1'b1;
				else
					busy <= 1'b1;
			end
			else if (busy && (shiftReg[31] != shiftReg[30]))
			begin
				busy <= 1'b0;
				normDone <= 1'b1;
			end
		end
	end

	// Datapath
	always_ff @(posedge clk)
	begin
		if (normReady)
		begin
			shiftReg <= normVar1;
			shiftCount <= 5'd0;
			if (normVar1 == 32'sd0)
				normValue <= 16'sd0;
			else if (normVar1 == -32'sd1)
				normValue <= 16'sd31;
		end
		else if (busy)
		begin
			if (shiftReg[31] != shiftReg[30])
				normValue <= {11'd0, shiftCount};
			else
			begin
				shiftReg <= shiftReg <<< 1;
				shiftCount <= shiftCount + 5'd1;
			end
		end
	end

endmodule

// File: design/scratchMemory.sv
`timescale 1ns/100ps
`include "corHX_macros.svh"

module scratchMemory
(
	input  logic clk,
	input  logic [`CORHX_ADDR_W-1:0] writeAddr,
	input  logic [`CORHX_DATA_W-1:0] writeData,
	input  logic writeEn,
	input  logic [`CORHX_ADDR_W-1:0] readAddr,
	output logic [`CORHX_DATA_W-1:0] readData
);

	// Covers the full 4096-word address space
	logic [`CORHX_DATA_W-1:0] mem [0:(1 << `CORHX_ADDR_W)-1];

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
	end

	// Read data arrives one cycle after the address
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

// File: design/corHXControl.sv
`timescale 1ns/100ps
`include "corHX_macros.svh"

module corHXControl
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [`CORHX_DATA_W-1:0] memIn,
	output logic [`CORHX_ADDR_W-1:0] memReadAddr,
	output logic [`CORHX_ADDR_W-1:0] memWriteAddr,
	output logic [`CORHX_DATA_W-1:0] memOut,
	output logic memWriteEn,
	output logic done,
	output g729TypesPkg::word32 normVar1,
	output logic normReady,
	input  g729TypesPkg::word16 normValue,
	input  logic normDone,
	output g729TypesPkg::word16 macA,
	output g729TypesPkg::word16 macB,
	output g729TypesPkg::word32 macC,
	input  g729TypesPkg::word32 macOut,
	output g729TypesPkg::word32 absIn,
	input  g729TypesPkg::word32 absOut,
	output g729TypesPkg::word32 subLA,
	output g729TypesPkg::word32 subLB,
	input  g729TypesPkg::word32 subLOut,
	output g729TypesPkg::word16 addA,
	output g729TypesPkg::word16 addB,
	input  g729TypesPkg::word16 addOut,
	output g729TypesPkg::word16 subA,
	output g729TypesPkg::word16 subB,
	input  g729TypesPkg::word16 subOut,
	output g729TypesPkg::word32 shrVar,
	output g729TypesPkg::word16 shrCount,
	input  g729TypesPkg::word32 shrOut
);

	corHXPkg::corHXState state;
	g729TypesPkg::word16 i;
	g729TypesPkg::word16 j;
	g729TypesPkg::word16 xReg;
	g729TypesPkg::word32 acc;
	g729TypesPkg::word32 maxReg;
	g729TypesPkg::word16 normReg;
	g729TypesPkg::word16 normLimit;
	g729TypesPkg::word16 shiftAmt;
	logic lastI;
	logic lastJ;

	assign lastI = (i == g729TypesPkg::word16'(`CORHX_L_SUBFR - 1));
	assign lastJ = (j == g729TypesPkg::word16'(`CORHX_L_SUBFR - 1));

	// norm_l result capped at 16
	assign normLimit = (normReg > 16'sd16) ? 16'sd16 : normReg;

	////////////////////////////////////////
	// Operator hookup
	////////////////////////////////////////

	// h sample arrives on memIn in MAC
	assign macA = xReg;
	assign macB = memIn[15:0];
	assign macC = acc;
	assign absIn = acc;
	assign subLA = absOut;
	assign subLB = maxReg;
	assign normVar1 = maxReg;
	assign shrVar = memIn;
	assign shrCount = shiftAmt;

	// add steps i in the outer loops and j in the inner loop
	assign addA = ((state == corHXPkg::FIND_MAX) || (state == corHXPkg::WRITE_DN)) ? i : j;
	assign addB = 16'sd1;
	// sub gives j - i for the h index, then 18 - norm
	assign subA = (state == corHXPkg::CALC_SHIFT) ? 16'sd18 : j;
	assign subB = (state == corHXPkg::CALC_SHIFT) ? normLimit : i;

	// Memory and strobe decode
	always_comb
	begin
		memReadAddr = `CORHX_X_BASE + j[`CORHX_ADDR_W-1:0];
		memWriteAddr = `CORHX_Y32_BASE + i[`CORHX_ADDR_W-1:0];
		memOut = acc;
		memWriteEn = 1'b0;
		normReady = 1'b0;
		done = 1'b0;
		case (state)
			corHXPkg::READ_H:
				memReadAddr = `CORHX_H_BASE + subOut[`CORHX_ADDR_W-1:0];
			corHXPkg::READ_Y:
				memReadAddr = `CORHX_Y32_BASE + i[`CORHX_ADDR_W-1:0];
			corHXPkg::STORE_Y:
				memWriteEn = 1'b1;
			corHXPkg::START_NORM:
				normReady = 1'b1;
			corHXPkg::WRITE_DN:
			begin
				// extract_l result stored sign-extended
				memWriteAddr = `CORHX_DN_BASE + i[`CORHX_ADDR_W-1:0];
				memOut = {{(`CORHX_DATA_W-16){shrOut[15]}}, shrOut[15:0]};
				memWriteEn = 1'b1;
			end
			corHXPkg::FINISH:
				done = 1'b1;
			default:
				;
		endcase
	end

	////////////////////////////////////////
	// State and loop counters
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= corHXPkg::IDLE;
			i <= 16'sd0;
			j <= 16'sd0;
		end
		else
		begin
			case (state)
				corHXPkg::IDLE:
				begin
					if (start)
					begin
						i <= 16'sd0;
						state <= corHXPkg::CLEAR_ACC;
					end
				end
				corHXPkg::CLEAR_ACC:
				begin
					j <= i;
					state <= corHXPkg::READ_X;
				end
				corHXPkg::READ_X:
					state <= corHXPkg::READ_H;
				corHXPkg::READ_H:
					state <= corHXPkg::MAC;
				corHXPkg::MAC:
				begin
					j <= addOut;
					state <= lastJ ? corHXPkg::STORE_Y : corHXPkg::READ_X;
				end
				corHXPkg::STORE_Y:
					state <= corHXPkg::FIND_MAX;
				corHXPkg::FIND_MAX:
				begin
					i <= addOut;
					state <= lastI ? corHXPkg::START_NORM : corHXPkg::CLEAR_ACC;
				end
				corHXPkg::START_NORM:
					state <= corHXPkg::WAIT_NORM;
				corHXPkg::WAIT_NORM:
				begin
					if (normDone)
						state <= corHXPkg::CALC_SHIFT;
				end
				corHXPkg::CALC_SHIFT:
				begin
					i <= 16'sd0;
					state <= corHXPkg::READ_Y;
				end
				corHXPkg::READ_Y:
					state <= corHXPkg::WRITE_DN;
				corHXPkg::WRITE_DN:
				begin
					i <= addOut;
					state <= lastI ? corHXPkg::FINISH : corHXPkg::READ_Y;
				end
				default:
					state <= corHXPkg::IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		case (state)
			corHXPkg::IDLE:
				maxReg <= 32'sd0;
			corHXPkg::CLEAR_ACC:
				acc <= 32'sd0;
			corHXPkg::READ_H:
				xReg <= memIn[15:0];
			corHXPkg::MAC:
				acc <= macOut;
			corHXPkg::FIND_MAX:
			begin
				// Only a strictly larger magnitude replaces the maximum
				if (subLOut > 0)
					maxReg <= absOut;
			end
			corHXPkg::WAIT_NORM:
			begin
				if (normDone)
					normReg <= normValue;
			end
			corHXPkg::CALC_SHIFT:
				shiftAmt <= subOut;
			default:
				;
		endcase
	end

endmodule

// File: design/corHXPipe.sv
`timescale 1ns/100ps
`include "corHX_macros.svh"

module corHXPipe
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic corHXMuxSel,
	input  logic [`CORHX_ADDR_W-1:0] testReadAddr,
	input  logic [`CORHX_ADDR_W-1:0] testWriteAddr,
	input  logic [`CORHX_DATA_W-1:0] testMemOut,
	input  logic testMemWriteEn,
	output logic [`CORHX_DATA_W-1:0] memIn,
	output logic done
);

	logic [`CORHX_ADDR_W-1:0] memReadAddr;
	logic [`CORHX_ADDR_W-1:0] memWriteAddr;
	logic [`CORHX_DATA_W-1:0] memOut;
	logic memWriteEn;
	logic [`CORHX_ADDR_W-1:0] muxReadAddr;
	logic [`CORHX_ADDR_W-1:0] muxWriteAddr;
	logic [`CORHX_DATA_W-1:0] muxWriteData;
	logic muxWriteEn;

	g729TypesPkg::word32 normVar1;
	g729TypesPkg::word16 normValue;
	logic normReady;
	logic normDone;

	// Operator nets between the FSM and basicOps
	g729TypesPkg::word16 macA;
	g729TypesPkg::word16 macB;
	g729TypesPkg::word32 macC;
	g729TypesPkg::word32 macOut;
	g729TypesPkg::word32 absIn;
	g729TypesPkg::word32 absOut;
	g729TypesPkg::word32 subLA;
	g729TypesPkg::word32 subLB;
	g729TypesPkg::word32 subLOut;
	g729TypesPkg::word16 addA;
	g729TypesPkg::word16 addB;
	g729TypesPkg::word16 addOut;
	g729TypesPkg::word16 subA;
	g729TypesPkg::word16 subB;
	g729TypesPkg::word16 subOut;
	g729TypesPkg::word32 shrVar;
	g729TypesPkg::word16 shrCount;
	g729TypesPkg::word32 shrOut;

	////////////////////////////////////////
	// Test port muxes
	////////////////////////////////////////

	assign muxReadAddr = corHXMuxSel ? testReadAddr : memReadAddr;
	assign muxWriteAddr = corHXMuxSel ? testWriteAddr : memWriteAddr;
	assign muxWriteData = corHXMuxSel ? testMemOut : memOut;
	assign muxWriteEn = corHXMuxSel ? testMemWriteEn : memWriteEn;

	scratchMemory testMem
	(
		.clk(clk),
		.writeAddr(muxWriteAddr),
		.writeData(muxWriteData),
		.writeEn(muxWriteEn),
		.readAddr(muxReadAddr),
		.readData(memIn)
	);

	corHXControl fsm (.*);

	basicOps ops (.*);

	normL norm (.*);

endmodule

// File: verification/corHXPipeTb.sv
`timescale 1ns/100ps
`include "corHX_macros.svh"

module corHXPipeTb;

	// Six runs of about 3500 cycles with loads and reads, plus margin
	localparam int cycleLimit = 40000;
	localparam int subLen = `CORHX_L_SUBFR;

	logic clk;
	logic rst;
	logic start;
	logic corHXMuxSel;
	logic [`CORHX_ADDR_W-1:0] testReadAddr;
	logic [`CORHX_ADDR_W-1:0] testWriteAddr;
	logic [`CORHX_DATA_W-1:0] testMemOut;
	logic testMemWriteEn;
	logic [`CORHX_DATA_W-1:0] memIn;
	logic done;

	g729TypesPkg::word16 xVec [0:`CORHX_L_SUBFR-1];
	g729TypesPkg::word16 hVec [0:`CORHX_L_SUBFR-1];
	g729TypesPkg::word16 expDn [0:`CORHX_L_SUBFR-1];
	g729TypesPkg::word16 gotDn [0:`CORHX_L_SUBFR-1];
	// Random case kept for the restart check
	g729TypesPkg::word16 randX [0:`CORHX_L_SUBFR-1];
	g729TypesPkg::word16 randH [0:`CORHX_L_SUBFR-1];

	logic [31:0] rngState;
	int errorCount;
	int testCount;
	int failedTests;
	int testStartErrors;
	int cycleCount;

	corHXPipe dut0
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.corHXMuxSel(corHXMuxSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testMemOut(testMemOut),
		.testMemWriteEn(testMemWriteEn),
		.memIn(memIn),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, the DUT never finished", cycleCount);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic g729TypesPkg::word32 macModel(input g729TypesPkg::word32 acc,
		input g729TypesPkg::word16 a, input g729TypesPkg::word16 b);
		longint prod;
		longint sum;
		prod = 2 * longint'(a) * longint'(b);
		// L_mult saturates before the add
		if (prod > 64'sh7FFF_FFFF)
			prod = 64'sh7FFF_FFFF;
		sum = longint'(acc) + prod;
		if (sum > 64'sh7FFF_FFFF)
			sum = 64'sh7FFF_FFFF;
		else if (sum < -64'sh8000_0000)
			sum = -64'sh8000_0000;
		return g729TypesPkg::word32'(sum);
	endfunction

	function automatic int normModel(input g729TypesPkg::word32 v);
		g729TypesPkg::word32 t;
		int n;
		n = 0;
		if (v == 0)
			return 0;
		if (v == -1)
			return 31;
		t = v[31] ? ~v : v;
		while (t < 32'sh4000_0000)
		begin
			t = t <<< 1;
			n++;
		end
		return n;
	endfunction

	// Cor_h_X on xVec and hVec into expDn
	task automatic computeExpected();
		g729TypesPkg::word32 y32 [0:`CORHX_L_SUBFR-1];
		g729TypesPkg::word32 absVal;
		g729TypesPkg::word32 maxVal;
		int normVal;
		int shiftBy;
		maxVal = 0;
		for (int i = 0; i < subLen; i++)
		begin
			y32[i] = 0;
			for (int j = i; j < subLen; j++)
				y32[i] = macModel(y32[i], xVec[j], hVec[j - i]);
			if (y32[i] == 32'sh8000_0000)
				absVal = 32'sh7FFF_FFFF;
			else if (y32[i] < 0)
				absVal = -y32[i];
			else
				absVal = y32[i];
			if (absVal > maxVal)
				maxVal = absVal;
		end
		normVal = normModel(maxVal);
		if (normVal > 16)
			normVal = 16;
		shiftBy = 18 - normVal;
		for (int i = 0; i < subLen; i++)
			expDn[i] = g729TypesPkg::word16'(y32[i] >>> shiftBy);
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic compareWord16(input string name, input g729TypesPkg::word16 got,
		input g729TypesPkg::word16 exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic compareWord32(input string name, input g729TypesPkg::word32 got,
		input g729TypesPkg::word32 exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic compareBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			errorCount++;
		end
	endtask

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	task automatic writeWord(input logic [`CORHX_ADDR_W-1:0] addr,
		input logic [`CORHX_DATA_W-1:0] data);
		@(negedge clk);
		corHXMuxSel = 1'b1;
		testWriteAddr = addr;
		testMemOut = data;
		testMemWriteEn = 1'b1;
		@(negedge clk);
		testMemWriteEn = 1'b0;
	endtask

	// Read data is valid at the next falling edge
	task automatic readWord(input logic [`CORHX_ADDR_W-1:0] addr,
		output logic [`CORHX_DATA_W-1:0] data);
		@(negedge clk);
		corHXMuxSel = 1'b1;
		testReadAddr = addr;
		@(negedge clk);
		data = memIn;
	endtask

	task automatic loadVectors();
		for (int k = 0; k < subLen; k++)
		begin
			writeWord(`CORHX_X_BASE + k, {{16{xVec[k][15]}}, xVec[k]});
			writeWord(`CORHX_H_BASE + k, {{16{hVec[k][15]}}, hVec[k]});
		end
	endtask

	task automatic runCorHX();
		@(negedge clk);
		corHXMuxSel = 1'b0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// Latency depends on the norm_l input
		while (done !== 1'b1)
			@(negedge clk);
		@(negedge clk);
		compareBit("done", done, 1'b0);
	endtask

	task automatic readAndCheckDn();
		logic [`CORHX_DATA_W-1:0] word;
		for (int k = 0; k < subLen; k++)
		begin
			readWord(`CORHX_DN_BASE + k, word);
			gotDn[k] = word[15:0];
			compareWord16($sformatf("dn[%0d]", k), gotDn[k], expDn[k]);
			// Upper half repeats the sign of dn
			compareWord16($sformatf("dn[%0d] upper half", k), word[31:16],
				{16{expDn[k][15]}});
		end
	endtask

	task automatic runAndCheck();
		loadVectors();
		computeExpected();
		runCorHX();
		readAndCheckDn();
	endtask

	task automatic beginTest();
		testStartErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errorCount == testStartErrors)
			$display("Test %0d %s: ok", testCount, name);
		else
		begin
			failedTests++;
			$display("Test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic idleAfterReset();
		beginTest();
		repeat (20)
		begin
			@(negedge clk);
			compareBit("done", done, 1'b0);
		end
		endTest("reset idle");
	endtask

	task automatic portReadback();
		logic [`CORHX_ADDR_W-1:0] addr;
		logic [`CORHX_DATA_W-1:0] data;
		logic [`CORHX_DATA_W-1:0] got;
		beginTest();
		for (int k = 0; k < 8; k++)
		begin
			addr = `CORHX_ADDR_W'(300 + k * 517);
			data = 32'(addr) * 32'h9E37_79B1 + 32'h0000_5A5A;
			writeWord(addr, data);
			readWord(addr, got);
			compareWord32($sformatf("memIn at 0x%h", addr), got, data);
		end
		endTest("test port readback");
	endtask

	task automatic impulseResponse();
		beginTest();
		for (int k = 0; k < subLen; k++)
		begin
			xVec[k] = g729TypesPkg::word16'((k - 20) * 512);
			hVec[k] = (k == 0) ? 16'sh4000 : 16'sh0000;
		end
		runAndCheck();
		endTest("impulse response");
	endtask

	task automatic randomVectors();
		g729TypesPkg::word16 r;
		beginTest();
		for (int k = 0; k < subLen; k++)
		begin
			rngState = xorshift32(rngState);
			r = rngState[15:0];
			xVec[k] = r >>> 3;
			rngState = xorshift32(rngState);
			r = rngState[15:0];
			hVec[k] = r >>> 3;
			randX[k] = xVec[k];
			randH[k] = hVec[k];
		end
		runAndCheck();
		endTest("random x and h");
	endtask

	task automatic saturatedInputs();
		beginTest();
		for (int k = 0; k < subLen; k++)
		begin
			xVec[k] = 16'sh7FFF;
			hVec[k] = 16'sh7FFF;
		end
		runAndCheck();
		endTest("saturation");
	endtask

	task automatic zeroThenRestart();
		beginTest();
		for (int k = 0; k < subLen; k++)
		begin
			xVec[k] = 16'sh0000;
			hVec[k] = 16'sh0000;
		end
		runAndCheck();
		// Same random case again after the zero run
		for (int k = 0; k < subLen; k++)
		begin
			xVec[k] = randX[k];
			hVec[k] = randH[k];
		end
		runAndCheck();
		endTest("zero input and restart");
	endtask

	initial
	begin
		rst = 1'b1;
		start = 1'b0;
		corHXMuxSel = 1'b0;
		testReadAddr = '0;
		testWriteAddr = '0;
		testMemOut = '0;
		testMemWriteEn = 1'b0;
		rngState = 32'd1;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		testStartErrors = 0;
		cycleCount = 0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		idleAfterReset();
		portReadback();
		impulseResponse();
		randomVectors();
		saturatedInputs();
		zeroThenRestart();

		$display("%0d tests run, %0d failed, %0d check errors", testCount, failedTests,
			errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
design/g729TypesPkg.sv
design/corHXPkg.sv
design/basicOps.sv
design/normL.sv
design/scratchMemory.sv
design/corHXControl.sv
design/corHXPipe.sv
verification/corHXPipeTb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST ?= verilog.f
TOP ?= corHXPipeTb
RTL_TOP ?= corHXPipe
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing -Wno-fatal

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
